//--- hw/cu_isa_pkg.sv
package cu_isa_pkg;

    localparam int ir_width  = 12; // opcode bits held in the IR
    localparam int reg_count = 16; // one select line per register

    typedef logic [reg_count-1:0] reg_sel_t;

    // bit position of each register on the read and write select buses
    typedef enum logic [3:0]
    {
        reg_ac, reg_pc, reg_ar, reg_ir,
        reg_r, reg_row, reg_cat, reg_cb,
        reg_rnow, reg_catnow, reg_cbnow, reg_alphap,
        reg_betap, reg_gammap, reg_total, reg_dr
    } reg_idx_e;

    typedef enum logic [ir_width-1:0]
    {
        op_clr = 0, op_load, op_mul, op_add,
        op_sub, op_inc, op_jump, op_jumpz,
        // accumulator to working register
        op_mvac_total = 8, op_mvac_alphap, op_mvac_betap, op_mvac_gammap,
        op_mvac_r, op_mvac_row, op_mvac_cat, op_mvac_cb,
        op_mvac_rnow, op_mvac_catnow, op_mvac_cbnow,
        // working register back to the accumulator
        op_mov_total = 19, op_mov_alphap, op_mov_betap, op_mov_gammap,
        op_mov_r, op_mov_row, op_mov_cat, op_mov_cb,
        op_mov_rnow, op_mov_catnow, op_mov_cbnow,
        op_store = 30, op_load_reg, op_endop
    } opcode_e;

    localparam opcode_e move_base_mvac = op_mvac_total;
    localparam opcode_e move_base_mov  = op_mov_total;
    localparam int      move_count     = 11;
    localparam int      move_idx_w     = $clog2(move_count);

    typedef logic [move_idx_w-1:0] move_idx_t;

    // both move groups list their targets in this same order
    localparam reg_idx_e move_targets [move_count] = '{
        reg_total, reg_alphap, reg_betap, reg_gammap, reg_r, reg_row,
        reg_cat, reg_cb, reg_rnow, reg_catnow, reg_cbnow
    };

    function automatic reg_sel_t reg_onehot(reg_idx_e idx);
        reg_sel_t sel;
        sel      = '0;
        sel[idx] = 1'b1;
        return sel;
    endfunction

    localparam reg_sel_t sel_none   = '0;
    localparam reg_sel_t sel_ac     = reg_onehot(reg_ac);
    localparam reg_sel_t sel_pc     = reg_onehot(reg_pc);
    localparam reg_sel_t sel_ar     = reg_onehot(reg_ar);
    localparam reg_sel_t sel_ir     = reg_onehot(reg_ir);
    localparam reg_sel_t sel_r      = reg_onehot(reg_r);
    localparam reg_sel_t sel_gammap = reg_onehot(reg_gammap);
    localparam reg_sel_t sel_dr     = reg_onehot(reg_dr);

endpackage

//--- hw/cu_ctrl_pkg.sv
package cu_ctrl_pkg;

    localparam int state_w   = 6;
    localparam int alu_op_w  = 3;
    localparam int mem_sel_w = 2;
    localparam int class_w   = 4;

    typedef enum logic [state_w-1:0]
    {
        st_idle,
        st_fetch1, st_fetch2, st_fetch3, st_fetch4,
        st_clr1,
        st_load1, st_load2, st_load3, st_load4, st_load5,
        st_mul1, st_add1, st_sub1, st_inc1,
        st_jump1, st_jump2, st_jump3,
        st_jumpzy1, st_jumpzy2, st_jumpzy3,
        st_jumpzn1, st_jumpzn2,
        st_mvac1, st_mov1, // one state per move direction, target comes from the IR
        st_store1, st_store2, st_store3,
        st_load_reg1, st_load_reg2, st_load_reg3, st_load_reg4,
        st_endop1
    } state_e;

    typedef enum logic [alu_op_w-1:0]
    {
        alu_nop = 0, alu_pass = 1, alu_add = 2, alu_sub = 3,
        alu_mul = 4, alu_plus1 = 5, alu_zero = 6
    } alu_op_e;

    // source that the DR latches from when a memory read is selected
    typedef enum logic [mem_sel_w-1:0]
    {
        mem_none = 0, mem_data = 1, mem_instr = 2
    } mem_sel_e;

    typedef enum logic [class_w-1:0]
    {
        cls_clr, cls_load, cls_mul, cls_add, cls_sub, cls_inc, cls_jump,
        cls_jumpz, cls_mvac, cls_mov, cls_store, cls_load_reg, cls_endop,
        cls_illegal
    } class_e;

endpackage

//--- hw/cu_ctrl_if.sv
// one cycle's worth of datapath controls
interface cu_ctrl_if;

    cu_isa_pkg::reg_sel_t  write_en; // one-hot, may carry two bits in fetch3
    cu_isa_pkg::reg_sel_t  read_en;
    cu_ctrl_pkg::mem_sel_e mem_read;
    logic                  mem_write;
    cu_ctrl_pkg::alu_op_e  alu_op;
    logic                  pc_inc;

    modport gen
    (
        output write_en, read_en, mem_read, mem_write, alu_op, pc_inc
    );

    modport sink
    (
        input write_en, read_en, mem_read, mem_write, alu_op, pc_inc
    );

endinterface

//--- hw/opcode_decoder.sv
module opcode_decoder
(
    input  cu_isa_pkg::opcode_e  opcode,
    output cu_ctrl_pkg::class_e  op_class,
    output cu_isa_pkg::reg_idx_e move_reg
);

    cu_isa_pkg::move_idx_t move_idx;

    always_comb
    begin
        op_class = cu_ctrl_pkg::cls_illegal;
        move_idx = '0;
        move_reg = cu_isa_pkg::reg_ac; // don't care outside the moves
        if (opcode >= cu_isa_pkg::move_base_mvac && opcode < cu_isa_pkg::move_base_mov)
        begin
            op_class = cu_ctrl_pkg::cls_mvac;
            move_idx = cu_isa_pkg::move_idx_t'(opcode - cu_isa_pkg::move_base_mvac);
            move_reg = cu_isa_pkg::move_targets[move_idx];
        end
        else if (opcode >= cu_isa_pkg::move_base_mov &&
                 opcode < cu_isa_pkg::move_base_mov + cu_isa_pkg::move_count)
        begin
            op_class = cu_ctrl_pkg::cls_mov;
            move_idx = cu_isa_pkg::move_idx_t'(opcode - cu_isa_pkg::move_base_mov);
            move_reg = cu_isa_pkg::move_targets[move_idx];
        end
        else
        begin
            case (opcode)
                cu_isa_pkg::op_clr:      op_class = cu_ctrl_pkg::cls_clr;
                cu_isa_pkg::op_load:     op_class = cu_ctrl_pkg::cls_load;
                cu_isa_pkg::op_mul:      op_class = cu_ctrl_pkg::cls_mul;
                cu_isa_pkg::op_add:      op_class = cu_ctrl_pkg::cls_add;
                cu_isa_pkg::op_sub:      op_class = cu_ctrl_pkg::cls_sub;
                cu_isa_pkg::op_inc:      op_class = cu_ctrl_pkg::cls_inc;
                cu_isa_pkg::op_jump:     op_class = cu_ctrl_pkg::cls_jump;
                cu_isa_pkg::op_jumpz:    op_class = cu_ctrl_pkg::cls_jumpz;
                cu_isa_pkg::op_store:    op_class = cu_ctrl_pkg::cls_store;
                cu_isa_pkg::op_load_reg: op_class = cu_ctrl_pkg::cls_load_reg;
                cu_isa_pkg::op_endop:    op_class = cu_ctrl_pkg::cls_endop;
                default:                 op_class = cu_ctrl_pkg::cls_illegal;
            endcase
        end
    end

endmodule

//--- hw/cu_sequencer.sv
module cu_sequencer
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                zflag,
    input  cu_ctrl_pkg::class_e op_class,
    output cu_ctrl_pkg::state_e state,
    output logic                endop
);

    cu_ctrl_pkg::state_e next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= cu_ctrl_pkg::st_idle;
        else
            state <= next_state;
    end

    // the opcode is stable from fetch4 on, so only fetch4 looks at op_class
    always_comb
    begin
        next_state = cu_ctrl_pkg::st_idle;
        case (state)
            cu_ctrl_pkg::st_idle:
            begin
                if (start)
                    next_state = cu_ctrl_pkg::st_fetch1;
            end
            cu_ctrl_pkg::st_fetch1: next_state = cu_ctrl_pkg::st_fetch2;
            cu_ctrl_pkg::st_fetch2: next_state = cu_ctrl_pkg::st_fetch3;
            cu_ctrl_pkg::st_fetch3: next_state = cu_ctrl_pkg::st_fetch4;
            cu_ctrl_pkg::st_fetch4:
            begin
                case (op_class)
                    cu_ctrl_pkg::cls_clr:      next_state = cu_ctrl_pkg::st_clr1;
                    cu_ctrl_pkg::cls_load:     next_state = cu_ctrl_pkg::st_load1;
                    cu_ctrl_pkg::cls_mul:      next_state = cu_ctrl_pkg::st_mul1;
                    cu_ctrl_pkg::cls_add:      next_state = cu_ctrl_pkg::st_add1;
                    cu_ctrl_pkg::cls_sub:      next_state = cu_ctrl_pkg::st_sub1;
                    cu_ctrl_pkg::cls_inc:      next_state = cu_ctrl_pkg::st_inc1;
                    cu_ctrl_pkg::cls_jump:     next_state = cu_ctrl_pkg::st_jump1;
                    cu_ctrl_pkg::cls_jumpz:
                    begin
                        if (zflag)
                            next_state = cu_ctrl_pkg::st_jumpzy1;
                        else
                            next_state = cu_ctrl_pkg::st_jumpzn1; // just skip the address word
                    end
                    cu_ctrl_pkg::cls_mvac:     next_state = cu_ctrl_pkg::st_mvac1;
                    cu_ctrl_pkg::cls_mov:      next_state = cu_ctrl_pkg::st_mov1;
                    cu_ctrl_pkg::cls_store:    next_state = cu_ctrl_pkg::st_store1;
                    cu_ctrl_pkg::cls_load_reg: next_state = cu_ctrl_pkg::st_load_reg1;
                    cu_ctrl_pkg::cls_endop:    next_state = cu_ctrl_pkg::st_endop1;
                    default:                   next_state = cu_ctrl_pkg::st_idle;
                endcase
            end

            cu_ctrl_pkg::st_load1: next_state = cu_ctrl_pkg::st_load2;
            cu_ctrl_pkg::st_load2: next_state = cu_ctrl_pkg::st_load3;
            cu_ctrl_pkg::st_load3: next_state = cu_ctrl_pkg::st_load4;
            cu_ctrl_pkg::st_load4: next_state = cu_ctrl_pkg::st_load5;

            cu_ctrl_pkg::st_jump1:   next_state = cu_ctrl_pkg::st_jump2;
            cu_ctrl_pkg::st_jump2:   next_state = cu_ctrl_pkg::st_jump3;
            cu_ctrl_pkg::st_jumpzy1: next_state = cu_ctrl_pkg::st_jumpzy2;
            cu_ctrl_pkg::st_jumpzy2: next_state = cu_ctrl_pkg::st_jumpzy3;
            cu_ctrl_pkg::st_jumpzn1: next_state = cu_ctrl_pkg::st_jumpzn2;

            cu_ctrl_pkg::st_store1: next_state = cu_ctrl_pkg::st_store2;
            cu_ctrl_pkg::st_store2: next_state = cu_ctrl_pkg::st_store3;

            cu_ctrl_pkg::st_load_reg1: next_state = cu_ctrl_pkg::st_load_reg2;
            cu_ctrl_pkg::st_load_reg2: next_state = cu_ctrl_pkg::st_load_reg3;
            cu_ctrl_pkg::st_load_reg3: next_state = cu_ctrl_pkg::st_load_reg4;

            // last cycle of every other instruction goes back to fetch
            cu_ctrl_pkg::st_clr1,
            cu_ctrl_pkg::st_load5,
            cu_ctrl_pkg::st_mul1,
            cu_ctrl_pkg::st_add1,
            cu_ctrl_pkg::st_sub1,
            cu_ctrl_pkg::st_inc1,
            cu_ctrl_pkg::st_jump3,
            cu_ctrl_pkg::st_jumpzy3,
            cu_ctrl_pkg::st_jumpzn2,
            cu_ctrl_pkg::st_mvac1,
            cu_ctrl_pkg::st_mov1,
            cu_ctrl_pkg::st_store3,
            cu_ctrl_pkg::st_load_reg4: next_state = cu_ctrl_pkg::st_fetch1;

            cu_ctrl_pkg::st_endop1: next_state = cu_ctrl_pkg::st_idle;
            default:                next_state = cu_ctrl_pkg::st_idle;
        endcase
    end

    // end flag stays up through idle until the next program is started
    always_ff @(posedge clk)
    begin
        if (reset)
            endop <= 1'b0;
        else if (state == cu_ctrl_pkg::st_idle && start)
            endop <= 1'b0;
        else if (state == cu_ctrl_pkg::st_endop1)
            endop <= 1'b1;
    end

endmodule

//--- hw/control_word_gen.sv
module control_word_gen
(
    input cu_ctrl_pkg::state_e  state,
    input cu_isa_pkg::reg_idx_e move_reg,
    cu_ctrl_if.gen              ctrl
);

    always_comb
    begin
        // quiet bus unless the state below says otherwise
        ctrl.write_en  = cu_isa_pkg::sel_none;
        ctrl.read_en   = cu_isa_pkg::sel_none;
        ctrl.mem_read  = cu_ctrl_pkg::mem_none;
        ctrl.mem_write = 1'b0;
        ctrl.alu_op    = cu_ctrl_pkg::alu_nop;
        ctrl.pc_inc    = 1'b0;

        case (state)
            cu_ctrl_pkg::st_fetch1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ar;
                ctrl.read_en  = cu_isa_pkg::sel_pc;
            end
            // instruction word lands in the DR straight from memory
            cu_ctrl_pkg::st_fetch2,
            cu_ctrl_pkg::st_jump1,
            cu_ctrl_pkg::st_jumpzy1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_dr;
                ctrl.mem_read = cu_ctrl_pkg::mem_instr;
                ctrl.pc_inc   = 1'b1;
            end
            cu_ctrl_pkg::st_fetch3:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ir | cu_isa_pkg::sel_ar;
                ctrl.read_en  = cu_isa_pkg::sel_dr | cu_isa_pkg::sel_pc;
            end

            cu_ctrl_pkg::st_clr1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.alu_op   = cu_ctrl_pkg::alu_zero;
            end
            cu_ctrl_pkg::st_mul1,
            cu_ctrl_pkg::st_add1,
            cu_ctrl_pkg::st_sub1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.read_en  = cu_isa_pkg::sel_r; // R is the second ALU operand
                if (state == cu_ctrl_pkg::st_mul1)
                    ctrl.alu_op = cu_ctrl_pkg::alu_mul;
                else if (state == cu_ctrl_pkg::st_add1)
                    ctrl.alu_op = cu_ctrl_pkg::alu_add;
                else
                    ctrl.alu_op = cu_ctrl_pkg::alu_sub;
            end
            cu_ctrl_pkg::st_inc1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.alu_op   = cu_ctrl_pkg::alu_plus1;
            end

            cu_ctrl_pkg::st_load1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_dr; // operand address follows the opcode
                ctrl.mem_read = cu_ctrl_pkg::mem_instr;
            end
            cu_ctrl_pkg::st_load2:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ar;
                ctrl.read_en  = cu_isa_pkg::sel_dr;
            end
            cu_ctrl_pkg::st_load3,
            cu_ctrl_pkg::st_jumpzn1:
                ctrl.pc_inc = 1'b1;
            // data memory answers one cycle after the address is set
            cu_ctrl_pkg::st_load4,
            cu_ctrl_pkg::st_load_reg3:
            begin
                ctrl.write_en = cu_isa_pkg::sel_dr;
                ctrl.mem_read = cu_ctrl_pkg::mem_data;
            end
            cu_ctrl_pkg::st_load5:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.read_en  = cu_isa_pkg::sel_dr | cu_isa_pkg::sel_pc;
                ctrl.alu_op   = cu_ctrl_pkg::alu_pass;
            end

            cu_ctrl_pkg::st_jump2,
            cu_ctrl_pkg::st_jumpzy2:
            begin
                ctrl.write_en = cu_isa_pkg::sel_pc;
                ctrl.read_en  = cu_isa_pkg::sel_dr;
            end
            // point AR back at the PC ready for the next fetch
            cu_ctrl_pkg::st_jump3,
            cu_ctrl_pkg::st_jumpzy3,
            cu_ctrl_pkg::st_jumpzn2,
            cu_ctrl_pkg::st_load_reg2:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ar;
                ctrl.read_en  = cu_isa_pkg::sel_pc;
            end

            cu_ctrl_pkg::st_mvac1:
            begin
                ctrl.write_en = cu_isa_pkg::reg_onehot(move_reg);
                ctrl.read_en  = cu_isa_pkg::sel_ac;
            end
            cu_ctrl_pkg::st_mov1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.read_en  = cu_isa_pkg::reg_onehot(move_reg);
                ctrl.alu_op   = cu_ctrl_pkg::alu_pass;
            end

            cu_ctrl_pkg::st_store1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ar;
                ctrl.read_en  = cu_isa_pkg::sel_gammap; // store address is kept in gammap
            end
            cu_ctrl_pkg::st_store2:
            begin
                ctrl.write_en  = cu_isa_pkg::sel_dr;
                ctrl.read_en   = cu_isa_pkg::sel_ac;
                ctrl.mem_write = 1'b1;
            end
            cu_ctrl_pkg::st_store3:
            begin
                ctrl.write_en  = cu_isa_pkg::sel_ar;
                ctrl.read_en   = cu_isa_pkg::sel_pc;
                ctrl.mem_write = 1'b1;
            end

            cu_ctrl_pkg::st_load_reg1:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ar; // AC holds the address
                ctrl.read_en  = cu_isa_pkg::sel_ac;
            end
            cu_ctrl_pkg::st_load_reg4:
            begin
                ctrl.write_en = cu_isa_pkg::sel_ac;
                ctrl.read_en  = cu_isa_pkg::sel_dr;
                ctrl.alu_op   = cu_ctrl_pkg::alu_pass;
            end

            default:
            begin
                ctrl.write_en = cu_isa_pkg::sel_none;
            end
        endcase
    end

endmodule

//--- hw/control_unit.sv
module control_unit
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            zflag,
    input  logic [cu_isa_pkg::ir_width-1:0]  opcode,
    output logic [cu_ctrl_pkg::alu_op_w-1:0] alu_op,
    output logic [cu_isa_pkg::reg_count-1:0] read_en,
    output logic [cu_isa_pkg::reg_count-1:0] write_en,
    output logic [cu_ctrl_pkg::mem_sel_w-1:0] mem_read,
    output logic                            mem_write,
    output logic                            pc_inc,
    output logic                            endop
);

    cu_ctrl_pkg::class_e  op_class;
    cu_isa_pkg::reg_idx_e move_reg;
    cu_ctrl_pkg::state_e  state;

    cu_ctrl_if ctrl_bus ();

    opcode_decoder u_decoder
    (
        .opcode   (cu_isa_pkg::opcode_e'(opcode)),
        .op_class (op_class),
        .move_reg (move_reg)
    );

    cu_sequencer u_sequencer
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .zflag    (zflag),
        .op_class (op_class),
        .state    (state),
        .endop    (endop)
    );

    control_word_gen u_word_gen
    (
        .state    (state),
        .move_reg (move_reg),
        .ctrl     (ctrl_bus.gen)
    );

    // control word goes out unregistered, in the same cycle as its state
    assign write_en  = ctrl_bus.write_en;
    assign read_en   = ctrl_bus.read_en;
    assign mem_read  = ctrl_bus.mem_read;
    assign mem_write = ctrl_bus.mem_write;
    assign alu_op    = ctrl_bus.alu_op;
    assign pc_inc    = ctrl_bus.pc_inc;

endmodule

//--- tb/control_unit_checker.sv
module control_unit_checker
(
    input logic        clk,
    input logic        reset,
    input logic        start,
    input logic        zflag,
    input logic [11:0] opcode,
    input logic [2:0]  alu_op,
    input logic [15:0] read_en,
    input logic [15:0] write_en,
    input logic [1:0]  mem_read,
    input logic        mem_write,
    input logic        pc_inc,
    input logic        endop
);

    int fail_count = 0;

    logic quiet;
    logic fetch3_seen;
    logic started; // first start since reset has been sampled

    function automatic logic [15:0] sel(cu_isa_pkg::reg_idx_e idx);
        return 16'(1) << idx;
    endfunction

    // move opcodes list their targets in the same order in both groups
    function automatic logic [15:0] move_sel(logic [11:0] k);
        case (k)
            12'd0:   return sel(cu_isa_pkg::reg_total);
            12'd1:   return sel(cu_isa_pkg::reg_alphap);
            12'd2:   return sel(cu_isa_pkg::reg_betap);
            12'd3:   return sel(cu_isa_pkg::reg_gammap);
            12'd4:   return sel(cu_isa_pkg::reg_r);
            12'd5:   return sel(cu_isa_pkg::reg_row);
            12'd6:   return sel(cu_isa_pkg::reg_cat);
            12'd7:   return sel(cu_isa_pkg::reg_cb);
            12'd8:   return sel(cu_isa_pkg::reg_rnow);
            12'd9:   return sel(cu_isa_pkg::reg_catnow);
            default: return sel(cu_isa_pkg::reg_cbnow);
        endcase
    endfunction

    assign quiet = write_en == 16'd0 && read_en == 16'd0 && mem_read == 2'd0 &&
                   !mem_write && alu_op == 3'd0 && !pc_inc;
    assign fetch3_seen = write_en == (sel(cu_isa_pkg::reg_ir) | sel(cu_isa_pkg::reg_ar)) &&
                         read_en == (sel(cu_isa_pkg::reg_dr) | sel(cu_isa_pkg::reg_pc));

    always_ff @(posedge clk)
    begin
        if (reset)
            started <= 1'b0;
        else if (start)
            started <= 1'b1;
    end

    property p_alu(logic [11:0] op, logic [15:0] we, logic [15:0] re, logic [2:0] alu);
        @(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == op) |=> write_en == we && read_en == re &&
            alu_op == alu && mem_read == 2'd0 && !mem_write && !pc_inc;
    endproperty

    a_reset: assert property (@(posedge clk) $past(reset) |-> quiet && !endop)
        else begin fail_count++; $error("outputs not quiet while in reset"); end
    a_idle: assert property (@(posedge clk) disable iff (reset) !started |-> quiet && !endop)
        else begin fail_count++; $error("outputs not quiet in idle before the first start"); end

    a_fetch: assert property (@(posedge clk) disable iff (reset)
        start |=> (write_en == sel(cu_isa_pkg::reg_ar) && read_en == sel(cu_isa_pkg::reg_pc) &&
                   !endop)
        ##1 (write_en == sel(cu_isa_pkg::reg_dr) && mem_read == 2'd2 && pc_inc)
        ##1 fetch3_seen)
        else begin fail_count++;
            $error("start in idle did not give the three fetch words or did not clear endop");
        end

    a_clr: assert property (p_alu(12'd0, sel(cu_isa_pkg::reg_ac), 16'd0, 3'd6))
        else begin fail_count++;
            $error("Mismatch clr: expected alu 6, actual %0d", $sampled(alu_op));
        end
    a_mul: assert property (p_alu(12'd2, sel(cu_isa_pkg::reg_ac), sel(cu_isa_pkg::reg_r), 3'd4))
        else begin fail_count++;
            $error("Mismatch mul: expected alu 4, actual %0d", $sampled(alu_op));
        end
    a_add: assert property (p_alu(12'd3, sel(cu_isa_pkg::reg_ac), sel(cu_isa_pkg::reg_r), 3'd2))
        else begin fail_count++;
            $error("Mismatch add: expected alu 2, actual %0d", $sampled(alu_op));
        end
    a_sub: assert property (p_alu(12'd4, sel(cu_isa_pkg::reg_ac), sel(cu_isa_pkg::reg_r), 3'd3))
        else begin fail_count++;
            $error("Mismatch sub: expected alu 3, actual %0d", $sampled(alu_op));
        end
    a_inc: assert property (p_alu(12'd5, sel(cu_isa_pkg::reg_ac), 16'd0, 3'd5))
        else begin fail_count++;
            $error("Mismatch inc: expected alu 5, actual %0d", $sampled(alu_op));
        end

    a_mvac: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode >= 12'd8 && opcode < 12'd19) |=>
        write_en == move_sel(opcode - 12'd8) && read_en == sel(cu_isa_pkg::reg_ac))
        else begin fail_count++;
            $error("Mismatch mvac: expected %h, actual %h", move_sel(opcode - 12'd8),
                   $sampled(write_en));
        end
    a_mov: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode >= 12'd19 && opcode < 12'd30) |=>
        write_en == sel(cu_isa_pkg::reg_ac) && read_en == move_sel(opcode - 12'd19) &&
        alu_op == 3'd1)
        else begin fail_count++;
            $error("Mismatch mov: expected %h, actual %h", move_sel(opcode - 12'd19),
                   $sampled(read_en));
        end

    a_jumpz_taken: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd7 && zflag) |=>
        (write_en == sel(cu_isa_pkg::reg_dr) && mem_read == 2'd2)
        ##1 (write_en == sel(cu_isa_pkg::reg_pc) && read_en == sel(cu_isa_pkg::reg_dr))
        ##1 (write_en == sel(cu_isa_pkg::reg_ar) && read_en == sel(cu_isa_pkg::reg_pc)))
        else begin fail_count++; $error("jumpz taken gave a wrong control sequence"); end
    a_jumpz_skip: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd7 && !zflag) |=>
        (pc_inc && write_en == 16'd0 && read_en == 16'd0 && mem_read == 2'd0)
        ##1 (write_en == sel(cu_isa_pkg::reg_ar) && read_en == sel(cu_isa_pkg::reg_pc)))
        else begin fail_count++; $error("jumpz not taken gave a wrong control sequence"); end

    a_store: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd30) |=> !mem_write ##1 mem_write ##1 mem_write)
        else begin fail_count++; $error("store did not strobe mem_write in cycles two and three"); end
    a_load: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd1) |=> ##3
        (write_en == sel(cu_isa_pkg::reg_dr) && mem_read == 2'd1)
        ##1 (write_en == sel(cu_isa_pkg::reg_ac) && alu_op == 3'd1))
        else begin fail_count++; $error("load missed its data read or accumulator write"); end
    a_load_reg: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd31) |=> ##2
        (write_en == sel(cu_isa_pkg::reg_dr) && mem_read == 2'd1)
        ##1 (write_en == sel(cu_isa_pkg::reg_ac) && alu_op == 3'd1))
        else begin fail_count++; $error("load_reg missed its data read or accumulator write"); end

    a_endop: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode == 12'd32) |=> quiet ##1 (endop && quiet) [*3])
        else begin fail_count++; $error("endop flag or idle controls wrong after end of operation"); end
    a_illegal: assert property (@(posedge clk) disable iff (reset)
        fetch3_seen ##1 (opcode > 12'd32) |=> quiet && endop == $past(endop) ##1 quiet)
        else begin fail_count++; $error("illegal opcode did not return quietly to idle"); end

endmodule

bind control_unit control_unit_checker u_chk (.*);

//--- tb/control_unit_tb.sv
module control_unit_tb;

    localparam int prog_len = 42;
    localparam int period   = 40;

    logic        clk;
    logic        reset;
    logic        start;
    logic        zflag;
    logic [11:0] opcode;
    logic [2:0]  alu_op;
    logic [15:0] read_en;
    logic [15:0] write_en;
    logic [1:0]  mem_read;
    logic        mem_write;
    logic        pc_inc;
    logic        endop;

    logic [11:0] prog [prog_len];
    int          prog_idx;
    int          seed;

    logic        taken_seen;
    logic        skip_seen;
    int          branch_gaps;

    control_unit u_dut
    (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .zflag     (zflag),
        .opcode    (opcode),
        .alu_op    (alu_op),
        .read_en   (read_en),
        .write_en  (write_en),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .pc_inc    (pc_inc),
        .endop     (endop)
    );

    initial
    begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // IR model, the next program word is loaded whenever the IR is written
    always @(negedge clk)
    begin
        if (!reset && write_en[cu_isa_pkg::reg_ir])
        begin
            if (prog_idx < prog_len)
                opcode <= prog[prog_idx];
            prog_idx <= prog_idx + 1;
        end
    end

    always @(negedge clk)
        zflag <= 1'($random(seed)); // both jumpz branches get taken over the run

    // the sequencer looks at zflag on the edge that ends fetch4
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && write_en[cu_isa_pkg::reg_ir] && prog_idx < prog_len &&
                prog[prog_idx] == 12'd7)
            begin
                repeat (2) @(posedge clk);
                if (zflag)
                    taken_seen = 1'b1;
                else
                    skip_seen = 1'b1;
            end
        end
    end

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // three quiet cycles in a row only happen in idle
    task automatic wait_idle();
        int run;
        run = 0;
        while (run < 3)
        begin
            @(negedge clk);
            if (write_en == 16'd0 && read_en == 16'd0 && !pc_inc && !mem_write)
                run++;
            else
                run = 0;
        end
    endtask

    initial
    begin
        repeat (prog_len * 12 + 200) @(negedge clk);
        $display("watchdog timeout: the DUT did not finish the program in time");
        $display("tests failed");
        $finish;
    end

    initial
    begin
        seed        = 32'h83ba3f29;
        reset       = 1'b1;
        start       = 1'b0;
        zflag       = 1'b0;
        opcode      = 12'd0;
        prog_idx    = 0;
        taken_seen  = 1'b0;
        skip_seen   = 1'b0;
        branch_gaps = 0;
        // run 1: every opcode but endop, extra jumpz, then an illegal code
        for (int i = 0; i < 32; i++)
            prog[i] = 12'(i);
        for (int i = 32; i < 36; i++)
            prog[i] = 12'd7;
        prog[36] = 12'd40;
        prog[37] = 12'd32; // run 2
        prog[38] = 12'd5;  // run 3
        prog[39] = 12'd7;
        prog[40] = 12'd7;
        prog[41] = 12'd32;

        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);

        pulse_start();
        wait (prog_idx >= 37);
        wait_idle();

        pulse_start();
        wait (endop);
        repeat (4) @(negedge clk);

        pulse_start();
        @(negedge clk);
        wait (endop);
        repeat (5) @(negedge clk);

        if (!taken_seen)
        begin
            branch_gaps++;
            $display("jumpz was never taken, so its taken sequence went unchecked");
        end
        if (!skip_seen)
        begin
            branch_gaps++;
            $display("jumpz was never skipped, so its not-taken sequence went unchecked");
        end

        $display("assertion failures: %0d, unreached jumpz branches: %0d",
                 u_dut.u_chk.fail_count, branch_gaps);
        if (u_dut.u_chk.fail_count == 0 && branch_gaps == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- control_unit.f
hw/cu_isa_pkg.sv
hw/cu_ctrl_pkg.sv
hw/cu_ctrl_if.sv
hw/opcode_decoder.sv
hw/cu_sequencer.sv
hw/control_word_gen.sv
hw/control_unit.sv
tb/control_unit_checker.sv
tb/control_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FILELIST  ?= control_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
